// ==== branch_predictor.f ====
hdl/bp_pkg.sv
hdl/gshare.sv
hdl/btb.sv
hdl/bp_csr.sv
hdl/branch_predictor.sv
testbench/tb_branch_predictor.sv

// ==== Makefile ====
# Verilator build and run of the branch predictor testbench
VERILATOR ?= verilator
TOP       ?= tb_branch_predictor
FILELIST  ?= branch_predictor.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list targets and variables"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

// ==== testbench/tb_branch_predictor.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_branch_predictor import bp_pkg::*; ();

  localparam int NUM_RES     = 400;
  // About five cycles per resolution covers the APB and sweep phases too
  localparam int CYCLE_LIMIT = 5 * (NUM_RES + 200);

  logic      clk_i;
  logic      rst_ni;
  pc_t       curr_pc_i, pred_target_o, res_pc_i, res_target_i, res_pred_target_i;
  logic      pred_taken_o, res_valid_i, res_taken_i, res_pred_taken_i;
  hist_t     pred_hist_o, res_hist_i;
  logic      psel_i, penable_i, pwrite_i, pready_o, pslverr_o;
  apb_addr_t paddr_i;
  apb_data_t pwdata_i, prdata_o;

  // Reference model state
  hist_t      m_hist;
  logic [1:0] m_pht [PHT_ROWS];
  logic       m_valid [BTB_ROWS];
  btb_tag_t   m_tag [BTB_ROWS];
  pc_t        m_target [BTB_ROWS];
  apb_data_t  m_nres, m_nmisp;
  logic       m_flush_pend, m_clear_pend;

  // Scenario flags driven with the stimulus
  logic  expect_cold, expect_zero, alias_hot, alias_probe;
  pc_t   hot_target;
  string test_name = "init";
  int    cycle_count = 0;
  logic [31:0] rng;
  pc_t   pool_pc [8];
  pc_t   pool_tgt [8];

  branch_predictor branch_predictor_i (.*);

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x;
    y = y ^ (y << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Counter step towards the outcome that saturates at both ends
  function automatic logic [1:0] sat_step(input logic [1:0] c, input logic up);
    if (up) return (c == 2'b11) ? c : c + 2'd1;
    return (c == 2'b00) ? c : c - 2'd1;
  endfunction

  task automatic report_mismatch(input string check, input logic [31:0] exp_v,
                                 input logic [31:0] act_v);
    $display("error %s (%s) expected 0x%0h actual 0x%0h", test_name, check, exp_v, act_v);
    $display("Checks failed");
    $fatal(1, "stopped at the first mismatch");
  endtask

  // ----------------------------------------------------------
  // Expected responses
  // ----------------------------------------------------------
  hist_t                exp_pht_idx, upd_idx;
  logic [BTB_IDX_W-1:0] exp_btb_idx;
  logic                 exp_hit, exp_taken, access, exp_err, model_misp, rd_nres, rd_nmisp;
  logic [1:0]           upd_next;
  pc_t                  exp_target;

  assign exp_pht_idx = m_hist ^ curr_pc_i[OFFSET +: HLEN];
  assign exp_btb_idx = curr_pc_i[OFFSET +: BTB_IDX_W];
  assign exp_hit     = m_valid[exp_btb_idx] &&
                       (m_tag[exp_btb_idx] == curr_pc_i[XLEN-1:OFFSET+BTB_IDX_W]);
  assign exp_target  = m_target[exp_btb_idx];
  // Taken needs the counter upper bit and a target
  assign exp_taken   = m_pht[exp_pht_idx][1] && exp_hit;
  assign upd_idx     = res_hist_i ^ res_pc_i[OFFSET +: HLEN];
  assign upd_next    = sat_step(m_pht[upd_idx], res_taken_i);
  assign model_misp  = (res_taken_i != res_pred_taken_i) ||
                       (res_taken_i && res_pred_taken_i && res_target_i != res_pred_target_i);
  assign access      = psel_i && penable_i;
  assign exp_err     = access && (!(paddr_i inside {ADDR_CTRL, ADDR_NRES, ADDR_NMISP}) ||
                       (pwrite_i && (paddr_i == ADDR_NRES || paddr_i == ADDR_NMISP)));
  assign rd_nres     = access && !pwrite_i && paddr_i == ADDR_NRES;
  assign rd_nmisp    = access && !pwrite_i && paddr_i == ADDR_NMISP;

  // Model updates on the DUT edge and applies flush and clear one cycle after the write
  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      m_hist <= '0;
      for (int i = 0; i < PHT_ROWS; i++) m_pht[i] <= INIT_C2B;
      for (int i = 0; i < BTB_ROWS; i++) m_valid[i] <= 1'b0;
      m_nres       <= '0;
      m_nmisp      <= '0;
      m_flush_pend <= 1'b0;
      m_clear_pend <= 1'b0;
    end else begin
      if (m_flush_pend) begin
        m_hist <= '0;
        for (int i = 0; i < PHT_ROWS; i++) m_pht[i] <= INIT_C2B;
        for (int i = 0; i < BTB_ROWS; i++) m_valid[i] <= 1'b0;
      end else if (res_valid_i) begin
        m_hist         <= {m_hist[HLEN-2:0], res_taken_i};
        m_pht[upd_idx] <= upd_next;
        if (res_taken_i) begin
          m_valid[res_pc_i[OFFSET +: BTB_IDX_W]]  <= 1'b1;
          m_tag[res_pc_i[OFFSET +: BTB_IDX_W]]    <= res_pc_i[XLEN-1:OFFSET+BTB_IDX_W];
          m_target[res_pc_i[OFFSET +: BTB_IDX_W]] <= res_target_i;
        end
      end
      if (m_clear_pend) begin
        m_nres  <= '0;
        m_nmisp <= '0;
      end else if (res_valid_i) begin
        m_nres <= m_nres + 32'd1;
        if (model_misp) m_nmisp <= m_nmisp + 32'd1;
      end
      m_flush_pend <= access && pwrite_i && paddr_i == ADDR_CTRL && pwdata_i[0];
      m_clear_pend <= access && pwrite_i && paddr_i == ADDR_CTRL && pwdata_i[1];
    end
  end

  // ----------------------------------------------------------
  // Checks
  // ----------------------------------------------------------
  a_hist: assert property (@(posedge clk_i) disable iff (!rst_ni) pred_hist_o == m_hist)
    else report_mismatch("history", 32'($sampled(m_hist)), 32'($sampled(pred_hist_o)));
  a_taken: assert property (@(posedge clk_i) disable iff (!rst_ni) pred_taken_o == exp_taken)
    else report_mismatch("direction", 32'($sampled(exp_taken)),
                         32'($sampled(pred_taken_o)));
  a_target: assert property (@(posedge clk_i) disable iff (!rst_ni)
    exp_hit |-> (pred_target_o == exp_target))
    else report_mismatch("target", $sampled(exp_target), $sampled(pred_target_o));
  // Cold predictor shows no taken and an empty history
  a_cold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    expect_cold |-> (!pred_taken_o && pred_hist_o == '0))
    else report_mismatch("cold state", 32'd0,
                         32'({$sampled(pred_hist_o), $sampled(pred_taken_o)}));
  a_hot: assert property (@(posedge clk_i) disable iff (!rst_ni)
    alias_hot |-> (pred_taken_o && pred_target_o == hot_target))
    else report_mismatch("trained pc", hot_target,
                         $sampled(pred_taken_o) ? $sampled(pred_target_o) : 32'd0);
  // A PC with the same index and another tag must miss
  a_alias: assert property (@(posedge clk_i) disable iff (!rst_ni) alias_probe |-> !pred_taken_o)
    else report_mismatch("alias miss", 32'd0, 32'($sampled(pred_taken_o)));
  a_rd_nres: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rd_nres |-> (prdata_o == m_nres))
    else report_mismatch("nres read", $sampled(m_nres), $sampled(prdata_o));
  a_rd_nmisp: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rd_nmisp |-> (prdata_o == m_nmisp))
    else report_mismatch("nmisp read", $sampled(m_nmisp), $sampled(prdata_o));
  a_rd_zero: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (expect_zero && (rd_nres || rd_nmisp)) |-> (prdata_o == '0))
    else report_mismatch("zero read", 32'd0, $sampled(prdata_o));
  a_ready: assert property (@(posedge clk_i) disable iff (!rst_ni) access |-> pready_o)
    else report_mismatch("pready", 32'd1, 32'($sampled(pready_o)));
  a_slverr: assert property (@(posedge clk_i) disable iff (!rst_ni)
    access |-> (pslverr_o == exp_err))
    else report_mismatch("pslverr", 32'($sampled(exp_err)), 32'($sampled(pslverr_o)));

  always @(posedge clk_i) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("Checks failed");
      $fatal(1, "cycle limit reached");
    end
  end

  // ----------------------------------------------------------
  // Stimulus tasks
  // ----------------------------------------------------------
  task automatic apb_access(input logic wr, input apb_addr_t addr, input apb_data_t data);
    @(negedge clk_i);
    psel_i    = 1'b1;
    penable_i = 1'b0;
    pwrite_i  = wr;
    paddr_i   = addr;
    pwdata_i  = data;
    @(negedge clk_i);
    penable_i = 1'b1;
    @(negedge clk_i);
    psel_i    = 1'b0;
    penable_i = 1'b0;
    pwrite_i  = 1'b0;
  endtask

  // Resolve the PC fetched one cycle earlier with its captured prediction
  task automatic run_resolutions(input int n);
    logic [2:0] k_cur;
    rng = xorshift32(rng);
    k_cur = rng[2:0];
    @(negedge clk_i);
    curr_pc_i = pool_pc[k_cur];
    for (int i = 0; i < n; i++) begin
      @(negedge clk_i);
      rng = xorshift32(rng);
      res_valid_i       = (rng[7:4] != 4'd0);
      res_pc_i          = curr_pc_i;
      res_hist_i        = pred_hist_o;
      res_pred_taken_i  = pred_taken_o;
      res_pred_target_i = pred_target_o;
      // Even pool slots lean taken, odd ones lean not taken
      res_taken_i  = k_cur[0] ? (rng[10:8] == 3'd0) : (rng[10:8] != 3'd0);
      res_target_i = (rng[15:12] == 4'd0) ? {rng[31:2], 2'b00} : pool_tgt[k_cur];
      k_cur        = rng[22:20];
      curr_pc_i    = pool_pc[k_cur];
    end
    @(negedge clk_i);
    res_valid_i = 1'b0;
  endtask

  task automatic train_taken(input pc_t pc, input pc_t target, input int n);
    @(negedge clk_i);
    curr_pc_i = pc;
    repeat (n) begin
      @(negedge clk_i);
      res_valid_i       = 1'b1;
      res_pc_i          = pc;
      res_hist_i        = pred_hist_o;
      res_pred_taken_i  = pred_taken_o;
      res_pred_target_i = pred_target_o;
      res_taken_i       = 1'b1;
      res_target_i      = target;
    end
    @(negedge clk_i);
    res_valid_i = 1'b0;
  endtask

  task automatic sweep_cold();
    for (int k = 0; k < 8; k++) begin
      @(negedge clk_i);
      expect_cold = 1'b1;
      curr_pc_i   = pool_pc[k[2:0]];
    end
    @(negedge clk_i);
    expect_cold = 1'b0;
  endtask

  // ----------------------------------------------------------
  // Test sequence
  // ----------------------------------------------------------
  initial begin
    rng = 32'd77426;
    // Slots 4, 5 and 7 alias slots 0, 2 and 1 in both tables
    pool_pc[0] = 32'h0000_1000;
    pool_pc[1] = 32'h0000_1004;
    pool_pc[2] = 32'h0000_1008;
    pool_pc[3] = 32'h0000_103C;
    pool_pc[4] = 32'h0000_2000;
    pool_pc[5] = 32'h0000_2008;
    pool_pc[6] = 32'h0000_1024;
    pool_pc[7] = 32'h8000_1004;
    for (int k = 0; k < 8; k++) pool_tgt[k[2:0]] = pool_pc[k[2:0]] ^ 32'h0004_0080;
    rst_ni = 1'b0;
    curr_pc_i = '0;
    {res_valid_i, res_taken_i, res_pred_taken_i} = 3'b000;
    {res_pc_i, res_target_i, res_pred_target_i} = '0;
    res_hist_i = '0;
    {psel_i, penable_i, pwrite_i} = 3'b000;
    paddr_i = '0;
    pwdata_i = '0;
    {expect_cold, expect_zero, alias_hot, alias_probe} = 4'b0000;
    hot_target = '0;
    repeat (5) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;

    test_name = "reset";
    sweep_cold();
    expect_zero = 1'b1;
    apb_access(1'b0, ADDR_NRES, '0);
    apb_access(1'b0, ADDR_NMISP, '0);
    expect_zero = 1'b0;

    test_name = "direction";
    run_resolutions(NUM_RES - 60);

    test_name = "target buffer";
    hot_target = 32'h0000_3000;
    train_taken(pool_pc[0], hot_target, 8);
    alias_hot = 1'b1;
    @(negedge clk_i);
    alias_hot   = 1'b0;
    alias_probe = 1'b1;
    curr_pc_i   = pool_pc[4];
    @(negedge clk_i);
    alias_probe = 1'b0;

    test_name = "statistics";
    apb_access(1'b0, ADDR_NRES, '0);
    apb_access(1'b0, ADDR_NMISP, '0);
    apb_access(1'b1, ADDR_CTRL, 32'h2);
    expect_zero = 1'b1;
    apb_access(1'b0, ADDR_NRES, '0);
    apb_access(1'b0, ADDR_NMISP, '0);
    expect_zero = 1'b0;

    test_name = "flush";
    run_resolutions(60);
    apb_access(1'b0, ADDR_NRES, '0);
    apb_access(1'b1, ADDR_CTRL, 32'h1);
    sweep_cold();
    apb_access(1'b0, ADDR_NRES, '0);
    apb_access(1'b0, ADDR_NMISP, '0);

    test_name = "apb error";
    apb_access(1'b0, 8'h0C, '0);
    apb_access(1'b1, ADDR_NRES, 32'hDEAD_BEEF);
    apb_access(1'b0, ADDR_NRES, '0);

    @(negedge clk_i);
    $display("All checks passed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== hdl/branch_predictor.sv ====
`timescale 1ns/10ps
`default_nettype none

module branch_predictor import bp_pkg::*; (
  input  wire logic      clk_i,
  input  wire logic      rst_ni,
  // Fetch stage
  input  wire pc_t       curr_pc_i,
  output logic           pred_taken_o,
  output pc_t            pred_target_o,
  output hist_t          pred_hist_o,
  // Execute stage resolution
  input  wire logic      res_valid_i,
  input  wire pc_t       res_pc_i,
  input  wire logic      res_taken_i,
  input  wire pc_t       res_target_i,
  input  wire hist_t     res_hist_i,
  input  wire logic      res_pred_taken_i,
  input  wire pc_t       res_pred_target_i,
  // APB register block
  input  wire logic      psel_i,
  input  wire logic      penable_i,
  input  wire logic      pwrite_i,
  input  wire apb_addr_t paddr_i,
  input  wire apb_data_t pwdata_i,
  output apb_data_t      prdata_o,
  output logic           pready_o,
  output logic           pslverr_o
);

  logic flush;
  logic gs_taken;
  logic btb_hit;

  // ----------------------------------------------------------
  // Direction predictor
  // ----------------------------------------------------------
  gshare gshare_i (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .flush_i     (flush),
    .curr_pc_i   (curr_pc_i),
    .res_valid_i (res_valid_i),
    .res_taken_i (res_taken_i),
    .res_pc_i    (res_pc_i),
    .res_hist_i  (res_hist_i),
    .taken_o     (gs_taken),
    .hist_o      (pred_hist_o)
  );

  // Target buffer
  btb btb_i (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .flush_i      (flush),
    .curr_pc_i    (curr_pc_i),
    .res_valid_i  (res_valid_i),
    .res_taken_i  (res_taken_i),
    .res_pc_i     (res_pc_i),
    .res_target_i (res_target_i),
    .hit_o        (btb_hit),
    .target_o     (pred_target_o)
  );

  // Control and statistics
  bp_csr bp_csr_i (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .psel_i            (psel_i),
    .penable_i         (penable_i),
    .pwrite_i          (pwrite_i),
    .paddr_i           (paddr_i),
    .pwdata_i          (pwdata_i),
    .prdata_o          (prdata_o),
    .pready_o          (pready_o),
    .pslverr_o         (pslverr_o),
    .res_valid_i       (res_valid_i),
    .res_taken_i       (res_taken_i),
    .res_target_i      (res_target_i),
    .res_pred_taken_i  (res_pred_taken_i),
    .res_pred_target_i (res_pred_target_i),
    .flush_o           (flush)
  );

  // Without a BTB hit there is no target, so fetch falls through
  assign pred_taken_o = gs_taken & btb_hit;

endmodule

`default_nettype wire

// ==== hdl/bp_csr.sv ====
`timescale 1ns/10ps
`default_nettype none

module bp_csr import bp_pkg::*; (
  input  wire logic      clk_i,
  input  wire logic      rst_ni,
  // APB slave
  input  wire logic      psel_i,
  input  wire logic      penable_i,
  input  wire logic      pwrite_i,
  input  wire apb_addr_t paddr_i,
  input  wire apb_data_t pwdata_i,
  output apb_data_t      prdata_o,
  output logic           pready_o,
  output logic           pslverr_o,
  // Resolution feedback for statistics
  input  wire logic      res_valid_i,
  input  wire logic      res_taken_i,
  input  wire pc_t       res_target_i,
  input  wire logic      res_pred_taken_i,
  input  wire pc_t       res_pred_target_i,
  // Predictor flush
  output logic           flush_o
);

  // Access phase qualifiers
  logic      access;
  logic      sel_ctrl;
  logic      sel_nres;
  logic      sel_nmisp;
  logic      addr_ok;
  logic      ctrl_wr;

  // Self-clearing control pulses
  logic      flush_q;
  logic      clear_q;

  // Statistics
  apb_data_t nres_q;
  apb_data_t nmisp_q;
  logic      mispredict;

  // ----------------------------------------------------------
  // Address decode
  // ----------------------------------------------------------
  assign access    = psel_i & penable_i;
  assign sel_ctrl  = (paddr_i == ADDR_CTRL);
  assign sel_nres  = (paddr_i == ADDR_NRES);
  assign sel_nmisp = (paddr_i == ADDR_NMISP);
  assign addr_ok   = sel_ctrl | sel_nres | sel_nmisp;
  assign ctrl_wr   = access & pwrite_i & sel_ctrl;

  // No wait states
  assign pready_o  = 1'b1;

  // Unknown address, or a write to a read-only counter
  assign pslverr_o = access & (!addr_ok | (pwrite_i & (sel_nres | sel_nmisp)));

  // CTRL holds only pulses and reads as zero
  always_comb begin
    prdata_o = '0;
    if (sel_nres) begin
      prdata_o = nres_q;
    end else if (sel_nmisp) begin
      prdata_o = nmisp_q;
    end
  end

  // ----------------------------------------------------------
  // Control pulses
  // ----------------------------------------------------------
  // One-cycle pulses raised on the cycle after the access phase
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      flush_q <= 1'b0;
      clear_q <= 1'b0;
    end else begin
      flush_q <= ctrl_wr & pwdata_i[0];
      clear_q <= ctrl_wr & pwdata_i[1];
    end
  end

  assign flush_o = flush_q;

  // ----------------------------------------------------------
  // Statistic counters
  // ----------------------------------------------------------
  // Wrong direction, or right direction but wrong target on taken
  assign mispredict = (res_taken_i != res_pred_taken_i) ||
                      (res_taken_i && res_pred_taken_i &&
                       (res_target_i != res_pred_target_i));

  // Clear has priority over counting and both counters wrap at 32 bits
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      nres_q  <= '0;
      nmisp_q <= '0;
    end else if (clear_q) begin
      nres_q  <= '0;
      nmisp_q <= '0;
    end else if (res_valid_i) begin
      nres_q <= nres_q + 1'b1;
      if (mispredict) begin
        nmisp_q <= nmisp_q + 1'b1;
      end
    end
  end

  // APB setup phase separates two writes, so flush never repeats
  a_flush_pulse: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    flush_o |=> !flush_o
  );

  // A rejected access raises neither flush nor clear
  a_slverr_no_pulse: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    pslverr_o |=> !(flush_o || clear_q)
  );

endmodule

`default_nettype wire

// ==== hdl/btb.sv ====
`timescale 1ns/10ps
`default_nettype none

module btb import bp_pkg::*; (
  input  wire logic clk_i,
  input  wire logic rst_ni,
  input  wire logic flush_i,
  // Fetch side lookup
  input  wire pc_t  curr_pc_i,
  // Resolution side update
  input  wire logic res_valid_i,
  input  wire logic res_taken_i,
  input  wire pc_t  res_pc_i,
  input  wire pc_t  res_target_i,
  // Lookup result
  output logic      hit_o,
  output pc_t       target_o
);

  // Entry storage
  logic     valid_q  [BTB_ROWS];
  btb_tag_t tag_q    [BTB_ROWS];
  pc_t      target_q [BTB_ROWS];

  // Split of the lookup and update PCs
  logic [BTB_IDX_W-1:0] idx_r;
  logic [BTB_IDX_W-1:0] idx_w;
  btb_tag_t             tag_r;
  btb_tag_t             tag_w;

  // Entries are written only by taken branches
  logic                 wr_en;

  // ----------------------------------------------------------
  // Address split
  // ----------------------------------------------------------
  assign idx_r = curr_pc_i[BTB_IDX_W+OFFSET-1:OFFSET];
  assign tag_r = curr_pc_i[XLEN-1:BTB_IDX_W+OFFSET];
  assign idx_w = res_pc_i[BTB_IDX_W+OFFSET-1:OFFSET];
  assign tag_w = res_pc_i[XLEN-1:BTB_IDX_W+OFFSET];

  assign wr_en = res_valid_i & res_taken_i;

  // ----------------------------------------------------------
  // Valid bits
  // ----------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < BTB_ROWS; i++) begin
        valid_q[i] <= 1'b0;
      end
    end else if (flush_i) begin
      // Flush wins over a same-cycle write
      for (int i = 0; i < BTB_ROWS; i++) begin
        valid_q[i] <= 1'b0;
      end
    end else if (wr_en) begin
      valid_q[idx_w] <= 1'b1;
    end
  end

  // ----------------------------------------------------------
  // Tags and targets
  // ----------------------------------------------------------
  // A taken resolution replaces whatever sits at its index
  always_ff @(posedge clk_i) begin
    if (wr_en) begin
      tag_q[idx_w]    <= tag_w;
      target_q[idx_w] <= res_target_i;
    end
  end

  // ----------------------------------------------------------
  // Lookup
  // ----------------------------------------------------------
  assign hit_o    = valid_q[idx_r] && (tag_q[idx_r] == tag_r);
  // Target is meaningful only together with hit_o
  assign target_o = target_q[idx_r];

  // A hit selects an entry written since reset, so its target is known
  a_hit_target_known: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    hit_o |-> !$isunknown(target_o)
  );

endmodule

`default_nettype wire

// ==== hdl/gshare.sv ====
`timescale 1ns/10ps
`default_nettype none

module gshare import bp_pkg::*; (
  input  wire logic  clk_i,
  input  wire logic  rst_ni,
  input  wire logic  flush_i,
  // Fetch side
  input  wire pc_t   curr_pc_i,
  // Resolution side
  input  wire logic  res_valid_i,
  input  wire logic  res_taken_i,
  input  wire pc_t   res_pc_i,
  input  wire hist_t res_hist_i,
  // Prediction
  output logic       taken_o,
  output hist_t      hist_o
);

  // Global history and counter table
  hist_t history_q;
  c2b_t  pht_q [PHT_ROWS];

  // Read and write indices
  hist_t index_r;
  hist_t index_w;

  // Counter selected by the resolution and its next state
  c2b_t  c2b_cur;
  c2b_t  c2b_next;

  // ----------------------------------------------------------
  // Index hashing
  // ----------------------------------------------------------
  // Fetch index uses the live history
  assign index_r = history_q ^ curr_pc_i[HLEN+OFFSET-1:OFFSET];
  // Training index uses the history snapshot taken at fetch,
  // so it lands on the same row that made the prediction
  assign index_w = res_hist_i ^ res_pc_i[HLEN+OFFSET-1:OFFSET];

  // ----------------------------------------------------------
  // Global history register
  // ----------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      history_q <= '0;
    end else if (flush_i) begin
      history_q <= '0;
    end else if (res_valid_i) begin
      // Newest outcome enters at bit 0
      history_q <= {history_q[HLEN-2:0], res_taken_i};
    end
  end

  // ----------------------------------------------------------
  // Saturating counter update
  // ----------------------------------------------------------
  assign c2b_cur = pht_q[index_w];

  always_comb begin
    c2b_next = c2b_cur;
    case (c2b_cur)
      SNT:     c2b_next = res_taken_i ? WNT : SNT;
      WNT:     c2b_next = res_taken_i ? WT  : SNT;
      WT:      c2b_next = res_taken_i ? ST  : WNT;
      ST:      c2b_next = res_taken_i ? ST  : WT;
      default: c2b_next = INIT_C2B;
    endcase
  end

  // Pattern history table, flush restores every row
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < PHT_ROWS; i++) begin
        pht_q[i] <= INIT_C2B;
      end
    end else if (flush_i) begin
      for (int i = 0; i < PHT_ROWS; i++) begin
        pht_q[i] <= INIT_C2B;
      end
    end else if (res_valid_i) begin
      pht_q[index_w] <= c2b_next;
    end
  end

  // ----------------------------------------------------------
  // Prediction outputs
  // ----------------------------------------------------------
  // Upper counter bit set means WT or ST
  assign taken_o = pht_q[index_r][1];
  assign hist_o  = history_q;

  // Direction must stay known once out of reset, any X in
  // the table or the fetch PC would leak into fetch redirect
  a_taken_known: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    !$isunknown(taken_o)
  );

endmodule

`default_nettype wire

// ==== hdl/bp_pkg.sv ====
`default_nettype none

package bp_pkg;

  // ----------------------------------------------------------
  // Widths and table sizes
  // ----------------------------------------------------------
  localparam int unsigned XLEN      = 32;
  // Byte offset bits, always zero for 32-bit instructions
  localparam int unsigned OFFSET    = 2;
  // History length, also the PHT index width
  localparam int unsigned HLEN      = 4;
  localparam int unsigned PHT_ROWS  = 1 << HLEN;
  localparam int unsigned BTB_IDX_W = 4;
  localparam int unsigned BTB_ROWS  = 1 << BTB_IDX_W;
  localparam int unsigned BTB_TAG_W = XLEN - OFFSET - BTB_IDX_W;

  // APB bus widths
  localparam int unsigned APB_AW = 8;
  localparam int unsigned APB_DW = 32;

  // ----------------------------------------------------------
  // Types
  // ----------------------------------------------------------
  typedef logic [XLEN-1:0]      pc_t;
  typedef logic [HLEN-1:0]      hist_t;
  typedef logic [BTB_TAG_W-1:0] btb_tag_t;
  typedef logic [APB_AW-1:0]    apb_addr_t;
  typedef logic [APB_DW-1:0]    apb_data_t;

  // 2-bit saturating counter states
  typedef enum logic [1:0] {
    SNT = 2'b00,
    WNT = 2'b01,
    WT  = 2'b10,
    ST  = 2'b11
  } c2b_t;

  // Register map
  localparam apb_addr_t ADDR_CTRL  = 8'h00;
  localparam apb_addr_t ADDR_NRES  = 8'h04;
  localparam apb_addr_t ADDR_NMISP = 8'h08;

  // Counter state after reset or flush
  localparam c2b_t INIT_C2B = WNT;

endpackage

`default_nettype wire
